/* Makefile */
# Verilator flow for the LDPC input buffer

VERILATOR  ?= verilator
TOP        ?= tb_ldpc_ibuf
RTL_TOP    ?= ldpc_ibuf_top
FILELIST   ?= filelist.f
OBJ_DIR    ?= obj_dir
PASS_MSG   ?= TEST PASSED
VFLAGS     ?= --timing --assert --timescale 1ns/1ps
LINT_FLAGS ?=

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: build
	$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

/* bench/ldpc_ibuf_patterns.txt */
# C len(dec) | F tag(hex) len(dec words) | S count(dec) samples(hex)
# a frame of len words takes 4*len samples, spread over S records
C 4
F a1 4
S 8 3 c 0 f 7 1 a 5
C 2
S 8 e 2 9 6 b 4 d 8
F b2 2
S 8 1 f 2 e 3 d 4 c
C 0
C 65
F c3 2
S 8 9 0 8 7 a 6 5 b
C 16
F d4 16
S 16 2 7 d 0 9 e 4 b 1 6 f 3 8 a c 5
S 16 f 0 e 1 d 2 c 3 b 4 a 5 9 6 8 7
S 16 5 a 3 c 7 1 e 9 0 b 6 2 d 4 f 8
S 16 8 4 2 1 c 6 3 9 e 7 b 5 a d f 0
C 1
F e5 1
S 4 6 2 f a
F f6 1
S 4 d 3 8 1
F 07 1
S 4 0 c 5 e

/* bench/tb_ldpc_ibuf.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ldpc_ibuf;

  import ldpc_ibuf_pkg::*;

  // one expected output word with its markers
  typedef struct packed {
    logic       sof;
    logic       eof;
    frame_tag_t tag;
    word_t      data;
  } exp_word_t;

  logic        iwclk = 1'b0;
  logic        arst_n;
  logic        cfg_write;
  flen_t       cfg_len;
  logic        in_valid;
  logic        in_sof;
  llr_t        in_llr;
  utag_t       in_tag;
  logic        in_ready;
  logic        out_valid;
  logic        out_sof;
  logic        out_eof;
  word_t       out_data;
  frame_tag_t  out_tag;
  logic        cfg_err;
  bank_flags_t flags;

  // --------------------
  // reference model state
  exp_word_t   exp_q[$];                  // words still owed by the DUT
  llr_t        smp_q[$];                  // samples of the frame being sent
  exp_word_t   got_exp;
  int          model_len  = 64;           // length after reset
  logic        model_err  = 1'b0;
  int          cur_len;                   // frozen at sof
  utag_t       cur_tag;
  int          frames_in  = 0;
  int          frames_out = 0;
  logic        saw_busy   = 1'b0;         // in_ready seen low at a frame start
  logic [31:0] rnd_state  = 32'habf74e3c;

  always #50 iwclk = ~iwclk;   // 100 ns period

  ldpc_ibuf_top DUT (
    .iwclk     (iwclk),
    .arst_n    (arst_n),
    .cfg_write (cfg_write),
    .cfg_len   (cfg_len),
    .in_valid  (in_valid),
    .in_sof    (in_sof),
    .in_llr    (in_llr),
    .in_tag    (in_tag),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_sof   (out_sof),
    .out_eof   (out_eof),
    .out_data  (out_data),
    .out_tag   (out_tag),
    .cfg_err   (cfg_err),
    .flags     (flags)
  );

  // --------------------
  // helpers
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("MISMATCH at %0t ns: %s, got %0h expected %0h",
                         $time, what, got, exp));
    end
  endtask

  task automatic drive_idle();
    @(posedge iwclk);
    in_valid  <= 1'b0;
    in_sof    <= 1'b0;
    cfg_write <= 1'b0;
  endtask

  task automatic drive_sample(input llr_t v, input logic sof, input utag_t t);
    rnd_state = xorshift32(rnd_state);
    if (rnd_state[2:0] == 3'd0) drive_idle();   // occasional gap
    @(posedge iwclk);
    in_valid  <= 1'b1;
    in_sof    <= sof;
    in_llr    <= v;
    in_tag    <= t;
    cfg_write <= 1'b0;
  endtask

  // cfg write followed by a compare of the sticky error
  task automatic write_cfg(input int v);
    @(posedge iwclk);
    cfg_write <= 1'b1;
    cfg_len   <= flen_t'(v);
    in_valid  <= 1'b0;
    in_sof    <= 1'b0;
    drive_idle();
    @(negedge iwclk);
    if (v != 0 && v <= 64) model_len = v;   // legal range 1..64
    else model_err = 1'b1;
    check_val(32'(cfg_err), 32'(model_err), "cfg_err after cfg write");
  endtask

  // caller has driven an idle cycle since the last sample
  task automatic wait_ready();
    int cnt;
    cnt = 0;
    @(negedge iwclk);
    while (!in_ready) begin
      saw_busy = 1'b1;
      check_val(32'(flags), 32'h3, "flags while both banks wait");   // any_full and all_full
      cnt++;
      if (cnt > 500) stop_run("timeout: in_ready stayed low, no bank was released");
      @(negedge iwclk);
    end
  endtask

  // sample 4w+l sits in lane l of word w
  task automatic push_frame();
    exp_word_t e;
    int        w;
    int        l;
    for (w = 0; w < cur_len; w++) begin
      e.sof      = (w == 0);
      e.eof      = (w == cur_len - 1);
      e.tag.utag = cur_tag;
      e.tag.flen = flen_t'(cur_len);
      for (l = 0; l < LANE_N; l++) begin
        e.data[l*LLR_W +: LLR_W] = smp_q[w*LANE_N + l];
      end
      exp_q.push_back(e);
    end
    frames_in++;
  endtask

  // --------------------
  // output monitor sampling at the falling edge
  always @(negedge iwclk) begin
    if (arst_n && out_valid) begin
      if (exp_q.size() == 0) begin
        stop_run("output word arrived with no frame pending");
      end else begin
        got_exp = exp_q.pop_front();
        check_val(32'(out_data), 32'(got_exp.data), "out_data");
        check_val(32'(out_sof), 32'(got_exp.sof), "out_sof");
        check_val(32'(out_eof), 32'(got_exp.eof), "out_eof");
        check_val(32'(out_tag), 32'(got_exp.tag), "out_tag");
        if (got_exp.eof) frames_out++;
      end
    end else if (arst_n) begin
      check_val(32'({out_sof, out_eof}), 32'd0, "frame marker without out_valid");
    end
  end

  // --------------------
  // stimulus from the pattern file
  initial begin : stim
    int            fd;
    int            code;
    int            v;
    int            n;
    int            tagv;
    int            k;
    int            i;
    int            cnt;
    logic          in_frm;
    logic [63:0]   tok;
    logic [1023:0] line;

    arst_n    = 1'b0;
    cfg_write = 1'b0;
    cfg_len   = '0;
    in_valid  = 1'b0;
    in_sof    = 1'b0;
    in_llr    = '0;
    in_tag    = '0;
    in_frm    = 1'b0;
    k         = 0;
    repeat (16) @(posedge iwclk);
    arst_n <= 1'b1;
    @(negedge iwclk);

    check_val(32'(out_valid), 32'd0, "out_valid after reset");
    check_val(32'(cfg_err), 32'd0, "cfg_err after reset");
    check_val(32'(in_ready), 32'd1, "in_ready after reset");
    check_val(32'(flags), 32'hc, "flags after reset");   // any_empty and all_empty

    fd = $fopen("bench/ldpc_ibuf_patterns.txt", "r");
    if (fd == 0) stop_run("cannot open bench/ldpc_ibuf_patterns.txt");
    while ($fscanf(fd, "%s", tok) == 1) begin
      if (tok == 64'("#")) begin
        code = $fgets(line, fd);   // skip comment text
      end else if (tok == 64'("C")) begin
        code = $fscanf(fd, "%d", v);
        if (code != 1) stop_run("malformed C record in pattern file");
        write_cfg(v);
      end else if (tok == 64'("F")) begin
        code = $fscanf(fd, "%h %d", tagv, v);
        if (code != 2) stop_run("malformed F record in pattern file");
        if (in_frm) stop_run("F record inside an unfinished frame");
        if (v != model_len) stop_run("F record length differs from the configured length");
        cur_tag = utag_t'(tagv);
        cur_len = model_len;
        k       = 0;
        in_frm  = 1'b1;
        smp_q.delete();
        wait_ready();
      end else if (tok == 64'("S")) begin
        code = $fscanf(fd, "%d", n);
        if (code != 1) stop_run("malformed S record in pattern file");
        for (i = 0; i < n; i++) begin
          code = $fscanf(fd, "%h", v);
          if (code != 1 || !in_frm) stop_run("sample in pattern file is outside a frame");
          smp_q.push_back(llr_t'(v));
          drive_sample(llr_t'(v), k == 0, cur_tag);
          k++;
          if (k == cur_len * LANE_N) begin
            push_frame();
            in_frm = 1'b0;
            drive_idle();   // frame closed
          end
        end
      end else begin
        stop_run("unknown record type in pattern file");
      end
    end
    $fclose(fd);
    if (in_frm) stop_run("pattern file ends inside a frame");

    // drain until the reader has released every bank
    cnt = 0;
    @(negedge iwclk);
    while (exp_q.size() != 0 || !flags.all_empty) begin
      cnt++;
      if (cnt > 1000) stop_run("timeout: output stream did not drain");
      @(negedge iwclk);
    end

    check_val(32'(frames_out), 32'(frames_in), "frames out vs frames in");
    check_val(32'(in_ready), 32'd1, "in_ready after drain");
    check_val(32'(cfg_err), 32'(model_err), "cfg_err at end");
    check_val(32'(saw_busy), 32'd1, "in_ready low while both banks waited");
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
src/ldpc_ibuf_pkg.sv
src/ldpc_ibuf_bank_ctrl.sv
src/ldpc_ibuf_cfg.sv
src/ldpc_ibuf_writer.sv
src/ldpc_ibuf_core.sv
src/ldpc_ibuf_reader.sv
src/ldpc_ibuf_top.sv
bench/tb_ldpc_ibuf.sv

/* src/ldpc_ibuf_bank_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

// ping-pong bookkeeping for the two banks
module ldpc_ibuf_bank_ctrl (
  input  logic                       iwclk,
  input  logic                       arst_n,
  input  logic                       wfull,    // writer closed a bank
  input  logic                       rempty,   // reader released a bank
  output ldpc_ibuf_pkg::bank_t       wbank,
  output ldpc_ibuf_pkg::bank_t       rbank,
  output ldpc_ibuf_pkg::bank_flags_t flags
);

  import ldpc_ibuf_pkg::*;

  logic [CNT_W-1:0] fill;   // number of banks holding a complete frame

  // --------------------
  // pointers
  always_ff @(posedge iwclk or negedge arst_n) begin
    if (!arst_n) begin
      wbank <= '0;
      rbank <= '0;
    end else begin
      if (wfull) begin
        wbank <= wbank + 1'b1;  // wraps over the banks
      end
      if (rempty) begin
        rbank <= rbank + 1'b1;
      end
    end
  end

  // --------------------
  // fill count
  always_ff @(posedge iwclk or negedge arst_n) begin
    if (!arst_n) begin
      fill <= '0;
    end else begin
      case ({wfull, rempty})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;        // both or none, no change
      endcase
    end
  end

  // flags straight from the count
  always_comb begin
    flags.all_empty = (fill == '0);
    flags.any_full  = (fill != '0);
    flags.all_full  = (fill == CNT_W'(BANK_N));
    flags.any_empty = !flags.all_full;   // some bank still free for the writer
  end

  // --------------------
  // writer must have been held off by in_ready, reader only frees what it owns
  a_no_overfill: assert property (@(posedge iwclk) disable iff (!arst_n)
    wfull |-> !flags.all_full);

  a_no_underrun: assert property (@(posedge iwclk) disable iff (!arst_n)
    rempty |-> !flags.all_empty);

endmodule

`default_nettype wire

/* src/ldpc_ibuf_cfg.sv */
`timescale 1ns/1ps
`default_nettype none

// frame length register
module ldpc_ibuf_cfg (
  input  logic                 iwclk,
  input  logic                 arst_n,
  input  logic                 cfg_write,
  input  ldpc_ibuf_pkg::flen_t cfg_len,
  output ldpc_ibuf_pkg::flen_t frame_len,
  output logic                 cfg_err     // sticky until reset
);

  import ldpc_ibuf_pkg::*;

  logic len_ok;

  // legal range 1..LEN_MAX words
  assign len_ok = (cfg_len != '0) && (cfg_len <= flen_t'(LEN_MAX));

  always_ff @(posedge iwclk or negedge arst_n) begin
    if (!arst_n) begin
      frame_len <= flen_t'(LEN_MAX);   // full bank by default
      cfg_err   <= 1'b0;
    end else if (cfg_write) begin
      if (len_ok) begin
        frame_len <= cfg_len;
      end else begin
        cfg_err <= 1'b1;               // keep old length
      end
    end
  end

endmodule

`default_nettype wire

/* src/ldpc_ibuf_core.sv */
`timescale 1ns/1ps
`default_nettype none

// two-bank buffer, LANE_N narrow write lanes, one wide read word
module ldpc_ibuf_core (
  input  logic                                iwclk,
  input  logic                                arst_n,
  // write side
  input  logic [ldpc_ibuf_pkg::LANE_N-1:0]    lane_we,   // one-hot lane strobe
  input  ldpc_ibuf_pkg::addr_t                waddr,
  input  ldpc_ibuf_pkg::llr_t                 wllr,
  input  logic                                wfull,
  input  ldpc_ibuf_pkg::frame_tag_t           wtag,
  // read side
  input  ldpc_ibuf_pkg::addr_t                raddr,
  input  logic                                rempty,
  output ldpc_ibuf_pkg::word_t                rdata,     // one cycle after raddr
  output ldpc_ibuf_pkg::frame_tag_t           rtag,
  output ldpc_ibuf_pkg::bank_flags_t          flags
);

  import ldpc_ibuf_pkg::*;

  bank_t wbank;
  bank_t rbank;

  // --------------------
  // bank pointers and flags
  ldpc_ibuf_bank_ctrl u_bank_ctrl (
    .iwclk  (iwclk),
    .arst_n (arst_n),
    .wfull  (wfull),
    .rempty (rempty),
    .wbank  (wbank),
    .rbank  (rbank),
    .flags  (flags)
  );

  // --------------------
  // lane memories
  // lane g holds sample g of every word, low lane in the low bits
  for (genvar g = 0; g < LANE_N; g++) begin : g_lane
    llr_t mem [BANK_N][2**ADDR_W];
    llr_t rd_q;   // registered read port

    always_ff @(posedge iwclk) begin
      if (lane_we[g]) begin
        mem[wbank][waddr] <= wllr;
      end
      rd_q <= mem[rbank][raddr];
    end

    assign rdata[g*LLR_W +: LLR_W] = rd_q;
  end

  // --------------------
  // tag ram
  // one entry per bank, loaded when the writer closes the frame
  frame_tag_t tram [BANK_N];

  always_ff @(posedge iwclk) begin
    if (wfull) begin
      tram[wbank] <= wtag;
    end
  end

  assign rtag = tram[rbank];   // async read, follows rbank

endmodule

`default_nettype wire

/* src/ldpc_ibuf_pkg.sv */
`default_nettype none

package ldpc_ibuf_pkg;

  // --------------------
  // widths
  localparam int LLR_W  = 4;                // one soft sample
  localparam int LANE_N = 4;                // samples per decoder word
  localparam int WORD_W = LLR_W * LANE_N;   // 16 bit decoder word
  localparam int ADDR_W = 6;                // word address inside one bank
  localparam int BNUM_W = 1;                // bank select, two banks
  localparam int LEN_W  = 7;                // frame length 1..64
  localparam int UTAG_W = 8;

  localparam int LANE_W  = $clog2(LANE_N);  // lane counter
  localparam int BANK_N  = 1 << BNUM_W;
  localparam int CNT_W   = BNUM_W + 1;      // fill count 0..BANK_N
  localparam int LEN_MAX = 1 << ADDR_W;     // longest legal frame, also reset value

  // --------------------
  // types
  typedef logic [LLR_W-1:0]  llr_t;
  typedef logic [WORD_W-1:0] word_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [BNUM_W-1:0] bank_t;
  typedef logic [LEN_W-1:0]  flen_t;
  typedef logic [UTAG_W-1:0] utag_t;

  // stored per bank, 15 bits
  typedef struct packed {
    utag_t utag;
    flen_t flen;   // length in force at sof
  } frame_tag_t;

  typedef struct packed {
    logic any_empty;
    logic all_empty;
    logic any_full;
    logic all_full;
  } bank_flags_t;

  typedef enum logic [1:0] {
    rd_idle,
    rd_stream,
    rd_release
  } rd_state_t;

endpackage

`default_nettype wire

/* src/ldpc_ibuf_reader.sv */
`timescale 1ns/1ps
`default_nettype none

// streams one full bank per frame, one word per cycle
module ldpc_ibuf_reader (
  input  logic                       iwclk,
  input  logic                       arst_n,
  input  ldpc_ibuf_pkg::bank_flags_t flags,
  input  ldpc_ibuf_pkg::frame_tag_t  rtag,
  input  ldpc_ibuf_pkg::word_t       rdata,
  output ldpc_ibuf_pkg::addr_t       raddr,
  output logic                       rempty,
  output logic                       out_valid,
  output logic                       out_sof,
  output logic                       out_eof,
  output ldpc_ibuf_pkg::word_t       out_data,
  output ldpc_ibuf_pkg::frame_tag_t  out_tag
);

  import ldpc_ibuf_pkg::*;

  rd_state_t state;
  addr_t     rd_addr;
  logic      streaming;
  logic      first_addr;
  logic      last_addr;

  assign streaming  = (state == rd_stream);
  assign first_addr = streaming && (rd_addr == '0);
  assign last_addr  = streaming && (flen_t'(rd_addr) + 1'b1 == rtag.flen);

  assign raddr    = rd_addr;
  assign rempty   = (state == rd_release);   // after the last address
  assign out_data = rdata;                   // ram latency matches marker delay

  // --------------------
  // fsm
  always_ff @(posedge iwclk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= rd_idle;
      rd_addr <= '0;
    end else begin
      case (state)
        rd_idle: begin
          if (flags.any_full) state <= rd_stream;
        end
        rd_stream: begin
          if (last_addr) begin
            state   <= rd_release;
            rd_addr <= '0;
          end else begin
            rd_addr <= rd_addr + 1'b1;
          end
        end
        rd_release: state <= rd_idle;   // bank handed back
        default:    state <= rd_idle;
      endcase
    end
  end

  // markers one cycle behind the address
  always_ff @(posedge iwclk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
      out_sof   <= 1'b0;
      out_eof   <= 1'b0;
    end else begin
      out_valid <= streaming;
      out_sof   <= first_addr;
      out_eof   <= last_addr;
    end
  end

  always_ff @(posedge iwclk) begin
    if (streaming) out_tag <= rtag;   // held through the eof word
  end

endmodule

`default_nettype wire

/* src/ldpc_ibuf_top.sv */
`timescale 1ns/1ps
`default_nettype none

// input buffer top, cfg -> writer -> core -> reader
module ldpc_ibuf_top (
  input  logic                       iwclk,
  input  logic                       arst_n,
  // configuration
  input  logic                       cfg_write,
  input  ldpc_ibuf_pkg::flen_t       cfg_len,
  // samples in
  input  logic                       in_valid,
  input  logic                       in_sof,
  input  ldpc_ibuf_pkg::llr_t        in_llr,
  input  ldpc_ibuf_pkg::utag_t       in_tag,
  output logic                       in_ready,
  // words out
  output logic                       out_valid,
  output logic                       out_sof,
  output logic                       out_eof,
  output ldpc_ibuf_pkg::word_t       out_data,
  output ldpc_ibuf_pkg::frame_tag_t  out_tag,
  // status
  output logic                       cfg_err,
  output ldpc_ibuf_pkg::bank_flags_t flags
);

  import ldpc_ibuf_pkg::*;

  flen_t             frame_len;
  logic [LANE_N-1:0] lane_we;
  addr_t             waddr;
  llr_t              wllr;
  logic              wfull;
  frame_tag_t        wtag;
  addr_t             raddr;
  logic              rempty;
  word_t             rdata;
  frame_tag_t        rtag;

  assign in_ready = !flags.all_full;   // source holds off while both banks wait

  ldpc_ibuf_cfg u_cfg (
    .iwclk     (iwclk),
    .arst_n    (arst_n),
    .cfg_write (cfg_write),
    .cfg_len   (cfg_len),
    .frame_len (frame_len),
    .cfg_err   (cfg_err)
  );

  ldpc_ibuf_writer u_writer (
    .iwclk     (iwclk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_sof    (in_sof),
    .in_llr    (in_llr),
    .in_tag    (in_tag),
    .frame_len (frame_len),
    .lane_we   (lane_we),
    .waddr     (waddr),
    .wllr      (wllr),
    .wfull     (wfull),
    .wtag      (wtag)
  );

  ldpc_ibuf_core u_core (
    .iwclk   (iwclk),
    .arst_n  (arst_n),
    .lane_we (lane_we),
    .waddr   (waddr),
    .wllr    (wllr),
    .wfull   (wfull),
    .wtag    (wtag),
    .raddr   (raddr),
    .rempty  (rempty),
    .rdata   (rdata),
    .rtag    (rtag),
    .flags   (flags)
  );

  ldpc_ibuf_reader u_reader (
    .iwclk     (iwclk),
    .arst_n    (arst_n),
    .flags     (flags),
    .rtag      (rtag),
    .rdata     (rdata),
    .raddr     (raddr),
    .rempty    (rempty),
    .out_valid (out_valid),
    .out_sof   (out_sof),
    .out_eof   (out_eof),
    .out_data  (out_data),
    .out_tag   (out_tag)
  );

endmodule

`default_nettype wire

/* src/ldpc_ibuf_writer.sv */
`timescale 1ns/1ps
`default_nettype none

// sample packer writing straight into the lane rams
module ldpc_ibuf_writer (
  input  logic                             iwclk,
  input  logic                             arst_n,
  input  logic                             in_valid,
  input  logic                             in_sof,
  input  ldpc_ibuf_pkg::llr_t              in_llr,
  input  ldpc_ibuf_pkg::utag_t             in_tag,
  input  ldpc_ibuf_pkg::flen_t             frame_len,
  output logic [ldpc_ibuf_pkg::LANE_N-1:0] lane_we,
  output ldpc_ibuf_pkg::addr_t             waddr,
  output ldpc_ibuf_pkg::llr_t              wllr,
  output logic                             wfull,    // same cycle as last sample
  output ldpc_ibuf_pkg::frame_tag_t        wtag
);

  import ldpc_ibuf_pkg::*;

  logic              in_frame;   // between sof and last sample
  logic [LANE_W-1:0] lane_cnt;   // lane of the next sample
  addr_t             word_cnt;   // word of the next sample
  logic              accept;
  logic              last;
  logic [LANE_W-1:0] cur_lane;
  addr_t             cur_word;

  // samples outside a frame without sof are dropped here
  assign accept   = in_valid && (in_sof || in_frame);
  assign cur_lane = in_sof ? '0 : lane_cnt;   // sof restarts at sample 0
  assign cur_word = in_sof ? '0 : word_cnt;

  // last lane of the last word but never the sof sample
  assign last = !in_sof && (lane_cnt == LANE_W'(LANE_N - 1)) &&
                (flen_t'(word_cnt) + 1'b1 == wtag.flen);

  assign lane_we = accept ? (LANE_N'(1) << cur_lane) : '0;
  assign waddr   = cur_word;
  assign wllr    = in_llr;
  assign wfull   = accept && last;

  // --------------------
  // position counters
  always_ff @(posedge iwclk or negedge arst_n) begin
    if (!arst_n) begin
      in_frame <= 1'b0;
      lane_cnt <= '0;
      word_cnt <= '0;
    end else if (accept) begin
      if (last) begin
        in_frame <= 1'b0;
        lane_cnt <= '0;
        word_cnt <= '0;
      end else begin
        in_frame <= 1'b1;
        lane_cnt <= cur_lane + 1'b1;   // wraps after lane 3
        word_cnt <= (cur_lane == LANE_W'(LANE_N - 1)) ? cur_word + 1'b1 : cur_word;
      end
    end
  end

  // tag and length frozen at sof
  always_ff @(posedge iwclk) begin
    if (accept && in_sof) begin
      wtag.utag <= in_tag;
      wtag.flen <= frame_len;
    end
  end

  // every write after sof lands inside the words of its own frame
  a_we_in_frame: assert property (@(posedge iwclk) disable iff (!arst_n)
    ((|lane_we) && !in_sof) |-> (flen_t'(waddr) < wtag.flen));

endmodule

`default_nettype wire
